//--- Bender.yml
package:
  name: cw_route

sources:
  - files:
      - design/cw_pkg.sv
      - design/cw_reg_file.sv
      - design/cw_trigger_route.sv
      - design/cw_power_fsm.sv
      - design/cw_ramp_timer.sv
      - design/cw_target_io.sv
      - design/cw_route_top.sv
  - target: test
    files:
      - bench/cw_route_chk.sv
      - bench/cw_route_tb.sv

//--- bench/cw_route_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cw_route_chk (
	input logic             clk,
	input logic             reset,
	input logic             req_i,
	input cw_pkg::reg_cmd_t cmd_i,
	input logic             ack_i,
	input logic [1:0]       power_state_i,
	input logic             target_power_off_i
);

	localparam logic [1:0] ST_ON = 2'd2;  // on encoding of the power fsm

	int fails = 0;  // failed assertion count

	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack_i) |-> $past(req_i))  // ack only answers a request
	else begin
		fails++;
		$error("ack rose without a pending request");
	end

	a_ack_holds: assert property (@(posedge clk) disable iff (reset)
		ack_i && req_i |=> ack_i)
	else begin
		fails++;
		$error("ack dropped while req was still high");
	end

	// host side rule
	a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
		req_i && $past(req_i) |-> $stable(cmd_i))
	else begin
		fails++;
		$error("command changed while req was high");
	end

	// powered target whenever the state register says on
	a_on_powered: assert property (@(posedge clk) disable iff (reset)
		power_state_i == ST_ON |-> !target_power_off_i)
	else begin
		fails++;
		$error("target power off while the fsm is on");
	end

endmodule

bind cw_route_top cw_route_chk i_chk (
	.clk                (clk),
	.reset              (reset),
	.req_i              (req_i),
	.cmd_i              (cmd_i),
	.ack_i              (ack_o),
	.power_state_i      (i_power.state_q),
	.target_power_off_i (target_power_off_o)
);

`default_nettype wire

//--- bench/cw_route_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cw_route_tb;

	localparam int NVEC = 5;
	localparam int TMO  = 20;  // cycles allowed per handshake phase
	localparam int RAMP = cw_pkg::RAMP_STEPS * cw_pkg::PWM_PERIOD;

	typedef struct packed {
		logic [7:0]         ts;
		logic [7:0]         tm;
		logic [31:0]        gpio;  // pin 4 byte on top
		cw_pkg::trig_in_t   trig;
		logic [3:0]         pins;
		logic               tx;
		logic               usi;
		cw_pkg::trig_out_t  exp_trig;
		cw_pkg::pin_drive_t exp_pins;
		logic               exp_rx;
		logic               exp_usi;
	} vec_t;

	logic               clk;
	logic               reset;
	logic               req;
	cw_pkg::reg_cmd_t   cmd;
	logic               ack;
	logic [7:0]         rdata;
	cw_pkg::trig_in_t   trig_in;
	cw_pkg::trig_out_t  trig_out;
	logic               uart_tx;
	logic               usi_out;
	logic [3:0]         pins_in;
	cw_pkg::pin_drive_t pins_out;
	logic               uart_rx;
	logic               usi_in;
	logic               avr_prog;
	logic [2:0]         aux_oe;
	logic [2:0]         aux_val;
	logic               tpo;
	int                 errors;
	int                 checks;
	vec_t               tbl [NVEC];

	cw_route_top i_dut (
		.clk                (clk),
		.reset              (reset),
		.req_i              (req),
		.cmd_i              (cmd),
		.ack_o              (ack),
		.rdata_o            (rdata),
		.trig_i             (trig_in),
		.trig_o             (trig_out),
		.uart_tx_i          (uart_tx),
		.usi_out_i          (usi_out),
		.pins_i             (pins_in),
		.pins_o             (pins_out),
		.uart_rx_o          (uart_rx),
		.usi_in_o           (usi_in),
		.avr_prog_o         (avr_prog),
		.aux_oe_o           (aux_oe),
		.aux_val_o          (aux_val),
		.target_power_off_o (tpo)
	);

	always #20 clk = ~clk;

	// reference trigger behavior over the enabled lines and the two selects
	function automatic cw_pkg::trig_out_t trig_model(input cw_pkg::trigsrc_t ts,
		input cw_pkg::trigmod_t tm, input cw_pkg::trig_in_t t);
		cw_pkg::trig_out_t r;
		logic [5:0]        ln;
		logic [5:0]        srcs;
		logic              any_hi;
		logic              all_hi;
		ln     = {t.io4, t.io3, t.io2, t.io1, t.fpb, t.fpa};
		any_hi = 1'b0;
		all_hi = 1'b1;
		for (int k = 0; k < 6; k++) begin
			if (ts.enables[k]) begin  // disabled lines drop out of both
				any_hi = any_hi | ln[k];
				all_hi = all_hi & ln[k];
			end
		end
		r.ext = (ts.mode == 2'd0) ? any_hi : (ts.mode == 2'd1) ? all_hi :
			(ts.mode == 2'd2) ? ~all_hi : 1'b0;
		srcs = {t.edge_trig, t.mmc, t.decodedio, t.anapattern, t.advio, r.ext};
		r.trigger[0] = (tm.pri_sel <= 3'd5) ? srcs[tm.pri_sel] : 1'b0;
		r.trigger[1] = (tm.sec_sel >= 3'd1 && tm.sec_sel <= 3'd5) ? srcs[tm.sec_sel] : 1'b0;
		r.fp_val = r.trigger[0] | r.trigger[1];
		r.fpa_oe = tm.fpa_out;
		r.fpb_oe = tm.fpb_out;
		return r;
	endfunction

	// one four phase transfer with bounded waits
	task automatic reg_xfer(input cw_pkg::reg_cmd_t c);
		int n;
		@(posedge clk);
		cmd <= c;
		req <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack !== 1'b1 && n < TMO);
		if (ack !== 1'b1) begin
			errors++;
			$display("error at %0t: no ack for request to address %0d", $time, c.addr);
		end
		@(posedge clk);
		req <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack !== 1'b0 && n < TMO);
		if (ack !== 1'b0) begin
			errors++;
			$display("error at %0t: ack stayed high after the request was dropped", $time);
		end
	endtask

	task automatic reg_write(input logic [5:0] addr, input logic [2:0] idx, input logic [7:0] d);
		reg_xfer({addr, idx, 1'b1, d});
	endtask

	task automatic reg_read(input logic [5:0] addr, input logic [2:0] idx, output logic [7:0] d);
		reg_xfer({addr, idx, 1'b0, 8'h00});
		d = rdata;  // held until the next read
	endtask

	task automatic check_trig(input string name, input cw_pkg::trig_out_t exp,
		input cw_pkg::trig_out_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_pins(input string name, input cw_pkg::pin_drive_t exp,
		input cw_pkg::pin_drive_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	initial begin
		logic [7:0]       rd;
		logic [7:0]       pat [10];
		cw_pkg::trigsrc_t ts;
		cw_pkg::trigmod_t tm;
		cw_pkg::trig_in_t ti;
		int               nhi;
		int               nlate;
		int               n;
		void'($urandom(68));
		clk     = 1'b0;
		reset   = 1'b1;
		req     = 1'b0;
		cmd     = '0;
		trig_in = '0;
		uart_tx = 1'b0;
		usi_out = 1'b0;
		pins_in = 4'h0;
		errors  = 0;
		checks  = 0;
		// trigsrc, trigmod, gpio bytes, trig_i, pins_i, tx, usi | trig_o, pins_o, rx, usi_in
		tbl[0] = {8'h01, 8'h00, 32'h00000201, 11'h400, 4'h0, 1'b0, 1'b1, 6'h19, 8'h10, 1'b0, 1'b1};
		tbl[1] = {8'h43, 8'h59, 32'hC0108405, 11'h408, 4'h0, 1'b1, 1'b0, 6'h27, 8'hF9, 1'b1, 1'b1};
		tbl[2] = {8'hBC, 8'hB0, 32'h82300A02, 11'h1A5, 4'h6, 1'b0, 1'b1, 6'h3B, 8'h80, 1'b0, 1'b1};
		tbl[3] = {8'hFF, 8'h6F, 32'h022808C0, 11'h7E4, 4'h4, 1'b0, 1'b1, 6'h25, 8'h51, 1'b0, 1'b0};
		tbl[4] = {8'h00, 8'h00, 32'h00000000, 11'h7FF, 4'h0, 1'b1, 1'b1, 6'h00, 8'h00, 1'b1, 1'b1};
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		reg_read(cw_pkg::ADDR_TRIGSRC, 3'd0, rd);
		check_byte("trigsrc", 8'h01, rd);  // front panel a only
		reg_read(cw_pkg::ADDR_TRIGMOD, 3'd0, rd);
		check_byte("trigmod", 8'h00, rd);
		for (int i = 0; i < 8; i++) begin
			reg_read(cw_pkg::ADDR_IOROUTE, i[2:0], rd);
			check_byte($sformatf("ioroute[%0d]", i),
				(i == 0) ? 8'h01 : (i == 1) ? 8'h02 : 8'h00, rd);
		end
		for (int i = 0; i < 10; i++) begin
			pat[i] = 8'($urandom);
		end
		for (int i = 0; i < 8; i++) begin
			reg_write(cw_pkg::ADDR_IOROUTE, i[2:0], pat[i]);
		end
		reg_write(cw_pkg::ADDR_TRIGSRC, 3'd0, pat[8]);
		reg_write(cw_pkg::ADDR_TRIGMOD, 3'd0, pat[9]);
		for (int i = 0; i < 8; i++) begin
			reg_read(cw_pkg::ADDR_IOROUTE, i[2:0], rd);
			check_byte($sformatf("ioroute[%0d]", i), pat[i], rd);
		end
		reg_read(cw_pkg::ADDR_TRIGSRC, 3'd0, rd);
		check_byte("trigsrc", pat[8], rd);
		reg_read(cw_pkg::ADDR_TRIGMOD, 3'd0, rd);
		check_byte("trigmod", pat[9], rd);
		reg_read(6'd0, 3'd0, rd);
		check_byte("unknown address", 8'h00, rd);
		for (int i = 0; i < 8; i++) begin
			reg_write(cw_pkg::ADDR_IOROUTE, i[2:0], 8'h00);  // power back on with no routing
		end

		// every mode and select code with random lines and enables
		for (int i = 0; i < 64; i++) begin
			ts.mode    = i[1:0];
			ts.enables = 6'($urandom);
			tm.pri_sel = i[4:2];
			tm.sec_sel = i[5:3];
			tm.fpa_out = 1'($urandom);
			tm.fpb_out = 1'($urandom);
			reg_write(cw_pkg::ADDR_TRIGSRC, 3'd0, ts);
			reg_write(cw_pkg::ADDR_TRIGMOD, 3'd0, tm);
			for (int k = 0; k < 4; k++) begin
				ti = 11'($urandom);
				@(posedge clk);
				trig_in <= ti;
				@(negedge clk);
				check_trig("trig_o", trig_model(ts, tm, ti), trig_out);
			end
		end

		for (int v = 0; v < NVEC; v++) begin
			reg_write(cw_pkg::ADDR_TRIGSRC, 3'd0, tbl[v].ts);
			reg_write(cw_pkg::ADDR_TRIGMOD, 3'd0, tbl[v].tm);
			for (int b = 0; b < 4; b++) begin
				reg_write(cw_pkg::ADDR_IOROUTE, b[2:0], tbl[v].gpio[8*b +: 8]);
			end
			@(posedge clk);
			trig_in <= tbl[v].trig;
			pins_in <= tbl[v].pins;
			uart_tx <= tbl[v].tx;
			usi_out <= tbl[v].usi;
			@(negedge clk);
			check_trig("trig_o", tbl[v].exp_trig, trig_out);
			check_pins("pins_o", tbl[v].exp_pins, pins_out);
			check_bit("uart_rx_o", tbl[v].exp_rx, uart_rx);
			check_bit("usi_in_o", tbl[v].exp_usi, usi_in);
		end

		rd = 8'($urandom);
		reg_write(cw_pkg::ADDR_IOROUTE, 3'd6, rd);
		reg_write(cw_pkg::ADDR_IOROUTE, 3'd5, 8'h01);  // avr programming, power on
		check_byte("aux_oe_o", {5'b0, rd[4], rd[2], rd[0]}, {5'b0, aux_oe});
		check_byte("aux_val_o", {5'b0, rd[5], rd[3], rd[1]}, {5'b0, aux_val});
		check_bit("avr_prog_o", 1'b1, avr_prog);

		reg_write(cw_pkg::ADDR_IOROUTE, 3'd0, 8'hC0);  // pin 1 static high
		check_pins("pins_o", 8'h11, pins_out);
		reg_write(cw_pkg::ADDR_IOROUTE, 3'd5, 8'h02);
		check_byte("pins_o.oe", 8'h00, {4'h0, pins_out.oe});
		check_bit("target_power_off_o", 1'b1, tpo);
		check_bit("avr_prog_o", 1'b0, avr_prog);
		reg_write(cw_pkg::ADDR_IOROUTE, 3'd5, 8'h04);  // fast start
		check_bit("target_power_off_o", 1'b0, tpo);
		check_pins("pins_o", 8'h11, pins_out);

		// slow start counted from the edge after the ack
		reg_write(cw_pkg::ADDR_IOROUTE, 3'd5, 8'h02);
		nhi   = 0;
		nlate = 0;
		fork
			reg_write(cw_pkg::ADDR_IOROUTE, 3'd5, 8'h00);
			begin
				n = 0;
				do begin
					@(negedge clk);
					n++;
				end while (ack !== 1'b1 && n < TMO);
				if (ack !== 1'b1) begin
					errors++;
					$display("error at %0t: no ack seen for the slow start request", $time);
				end
				for (int c = 0; c < RAMP + 40; c++) begin
					@(negedge clk);
					if (tpo === 1'b1 && c < RAMP) nhi++;
					if (tpo !== 1'b0 && c >= RAMP) nlate++;  // must stay low after ramp
				end
			end
		join
		check_byte("ramp off cycles", 8'(cw_pkg::RAMP_STEPS * cw_pkg::PWM_OFF_CYCLES), 8'(nhi));
		check_byte("off cycles after ramp", 8'h00, 8'(nlate));

		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, i_dut.i_chk.fails);
		if (errors == 0 && i_dut.i_chk.fails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/cw_pkg.sv
`default_nettype none

package cw_pkg;

	// host request, held stable by the host while req is high
	typedef struct packed {
		logic [5:0] addr;
		logic [2:0] byte_idx;  // selects the io routing byte
		logic       write;
		logic [7:0] wdata;
	} reg_cmd_t;

	typedef struct packed {
		logic [1:0] mode;     // 0 or, 1 and, 2 nand, 3 constant low
		logic [5:0] enables;  // bit 0 fpa, bit 1 fpb, bits 2..5 io1..io4
	} trigsrc_t;

	typedef struct packed {
		logic [2:0] sec_sel;  // same coding as pri_sel but 0 is off
		logic       fpb_out;
		logic       fpa_out;
		logic [2:0] pri_sel;
	} trigmod_t;

	typedef struct packed {
		logic drive_en;   // static drive when nothing else claims the pin
		logic drive_val;
		logic txo_oc;     // open collector uart tx, pin 3 only
		logic usio_oc;    // open collector usi out, pin 3 only
		logic usi_rx;
		logic usi_tx;
		logic uart_rx;
		logic uart_tx;
	} gpio_cfg_t;

	typedef struct packed {
		logic [4:0] unused;
		logic       fast_start;
		logic       power_off;
		logic       avr_prog;
	} extra_cfg_t;

	typedef struct packed {
		logic [1:0] unused;
		logic       pdic;
		logic       pdic_en;
		logic       pdid;
		logic       pdid_en;
		logic       nrst;
		logic       nrst_en;
	} aux_gpio_t;

	// byte 0 is pin 1, byte 7 sits at the top
	typedef struct packed {
		logic [7:0]      rsvd7;
		aux_gpio_t       aux;
		extra_cfg_t      extra;
		logic [7:0]      unused4;
		gpio_cfg_t [3:0] gpio;
	} io_route_t;

	typedef struct packed {
		trigsrc_t  trigsrc;
		trigmod_t  trigmod;
		io_route_t ioroute;
	} cw_cfg_t;

	typedef struct packed {
		logic fpa;
		logic fpb;
		logic io1;
		logic io2;
		logic io3;
		logic io4;
		logic advio;
		logic anapattern;
		logic decodedio;
		logic mmc;
		logic edge_trig;  // edge trigger module
	} trig_in_t;

	typedef struct packed {
		logic [1:0] trigger;  // bit 0 primary, bit 1 secondary
		logic       ext;
		logic       fpa_oe;
		logic       fpb_oe;
		logic       fp_val;
	} trig_out_t;

	typedef struct packed {
		logic [3:0] oe;
		logic [3:0] val;
	} pin_drive_t;

	localparam logic [5:0] ADDR_TRIGSRC = 6'd39;
	localparam logic [5:0] ADDR_IOROUTE = 6'd55;
	localparam logic [5:0] ADDR_TRIGMOD = 6'd40;

	localparam trigsrc_t  RST_TRIGSRC = 8'h01;                  // front panel a only, or mode
	localparam io_route_t RST_IOROUTE = 64'h0000_0000_0000_0201; // pin1 tx, pin2 rx

	localparam int PWM_PERIOD     = 16;  // cycles per pwm period
	localparam int PWM_OFF_CYCLES = 6;   // off window at start of each period
	localparam int RAMP_STEPS     = 8;   // periods in one soft start
	localparam int PHASE_W        = $clog2(PWM_PERIOD);
	localparam int STEP_W         = $clog2(RAMP_STEPS);

endpackage

`default_nettype wire

//--- design/cw_power_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cw_power_fsm (
	input  logic               clk,
	input  logic               reset,
	input  cw_pkg::extra_cfg_t extra_i,
	input  logic               pwm_off_i,
	input  logic               done_i,
	output logic               run_o,
	output logic               power_off_q_o,
	output logic               target_power_off_o
);

	typedef enum logic [1:0] {
		ST_OFF  = 2'd0,
		ST_RAMP = 2'd1,
		ST_ON   = 2'd2
	} state_t;

	state_t state_q;
	state_t state_d;

	// next state follows the raw request so state and power_off_q move together
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_ON: begin
				if (extra_i.power_off) state_d = ST_OFF;
			end
			ST_OFF: begin
				if (!extra_i.power_off) begin  // off to on edge
					state_d = extra_i.fast_start ? ST_ON : ST_RAMP;
				end
			end
			ST_RAMP: begin
				if (extra_i.power_off) state_d = ST_OFF;  // abort wins over done
				else if (done_i) state_d = ST_ON;
			end
			default: state_d = ST_OFF;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q       <= ST_ON;  // power_off resets to zero
			power_off_q_o <= 1'b0;
		end else begin
			state_q       <= state_d;
			power_off_q_o <= extra_i.power_off;
		end
	end

	assign run_o              = (state_q == ST_RAMP);
	assign target_power_off_o = run_o ? pwm_off_i : power_off_q_o;

endmodule

`default_nettype wire

//--- design/cw_ramp_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cw_ramp_timer (
	input  logic clk,
	input  logic reset,
	input  logic run_i,
	output logic pwm_off_o,
	output logic done_o
);

	logic [cw_pkg::PHASE_W-1:0] phase_q;  // position inside the pwm period
	logic [cw_pkg::STEP_W-1:0]  step_q;   // completed periods
	logic                       period_end;
	logic                       last_step;

	assign period_end = (phase_q == cw_pkg::PHASE_W'(cw_pkg::PWM_PERIOD - 1));
	assign last_step  = (step_q == cw_pkg::STEP_W'(cw_pkg::RAMP_STEPS - 1));

	// held at zero while idle, so every ramp starts at phase zero
	always_ff @(posedge clk) begin
		if (reset || !run_i) begin
			phase_q <= '0;
			step_q  <= '0;
		end else if (period_end) begin
			phase_q <= '0;
			step_q  <= step_q + 1'b1;
		end else begin
			phase_q <= phase_q + 1'b1;
		end
	end

	// power stays off for the first part of each period
	assign pwm_off_o = run_i & (phase_q < cw_pkg::PHASE_W'(cw_pkg::PWM_OFF_CYCLES));
	assign done_o    = run_i & period_end & last_step;  // one cycle at ramp end

endmodule

`default_nettype wire

//--- design/cw_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module cw_reg_file (
	input  logic             clk,
	input  logic             reset,
	input  logic             req_i,
	input  cw_pkg::reg_cmd_t cmd_i,
	output logic             ack_o,
	output logic [7:0]       rdata_o,
	output cw_pkg::cw_cfg_t  cfg_o
);

	cw_pkg::trigsrc_t  trigsrc_q;
	cw_pkg::trigmod_t  trigmod_q;
	logic [7:0][7:0]   ioroute_q;  // byte addressed view of io routing
	logic              accept;
	logic [7:0]        rd_mux;

	assign accept = req_i & ~ack_o;  // first cycle of a new request

	// four phase ack, held until req drops
	always_ff @(posedge clk) begin
		if (reset) begin
			ack_o <= 1'b0;
		end else if (accept) begin
			ack_o <= 1'b1;
		end else if (!req_i) begin
			ack_o <= 1'b0;  // release one cycle after req falls
		end
	end

	always_comb begin
		case (cmd_i.addr)
			cw_pkg::ADDR_TRIGSRC: rd_mux = trigsrc_q;
			cw_pkg::ADDR_TRIGMOD: rd_mux = trigmod_q;
			cw_pkg::ADDR_IOROUTE: rd_mux = ioroute_q[cmd_i.byte_idx];
			default:              rd_mux = 8'h00;  // unknown reads as zero
		endcase
	end

	// read data captured with the ack, stable while ack is high
	always_ff @(posedge clk) begin
		if (accept && !cmd_i.write) begin
			rdata_o <= rd_mux;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q <= cw_pkg::RST_TRIGSRC;
			trigmod_q <= '0;
			ioroute_q <= cw_pkg::RST_IOROUTE;
		end else if (accept && cmd_i.write) begin
			case (cmd_i.addr)
				cw_pkg::ADDR_TRIGSRC: trigsrc_q <= cmd_i.wdata;
				cw_pkg::ADDR_TRIGMOD: trigmod_q <= cmd_i.wdata;
				cw_pkg::ADDR_IOROUTE: ioroute_q[cmd_i.byte_idx] <= cmd_i.wdata;
				default: ;  // unknown address, nothing changes
			endcase
		end
	end

	// register contents go straight out, so a write shows with the ack
	assign cfg_o.trigsrc = trigsrc_q;
	assign cfg_o.trigmod = trigmod_q;
	assign cfg_o.ioroute = cw_pkg::io_route_t'(ioroute_q);

endmodule

`default_nettype wire

//--- design/cw_route_top.sv
`timescale 1ns/1ps
`default_nettype none

module cw_route_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               req_i,
	input  cw_pkg::reg_cmd_t   cmd_i,
	output logic               ack_o,
	output logic [7:0]         rdata_o,
	input  cw_pkg::trig_in_t   trig_i,
	output cw_pkg::trig_out_t  trig_o,
	input  logic               uart_tx_i,
	input  logic               usi_out_i,
	input  logic [3:0]         pins_i,
	output cw_pkg::pin_drive_t pins_o,
	output logic               uart_rx_o,
	output logic               usi_in_o,
	output logic               avr_prog_o,
	output logic [2:0]         aux_oe_o,
	output logic [2:0]         aux_val_o,
	output logic               target_power_off_o
);

	cw_pkg::cw_cfg_t cfg;
	logic            pwm_off;
	logic            done;
	logic            run;
	logic            power_off_q;  // also the pin high-z condition

	cw_reg_file i_reg_file (
		.clk     (clk),
		.reset   (reset),
		.req_i   (req_i),
		.cmd_i   (cmd_i),
		.ack_o   (ack_o),
		.rdata_o (rdata_o),
		.cfg_o   (cfg)
	);

	cw_trigger_route i_trig (
		.trigsrc_i (cfg.trigsrc),
		.trigmod_i (cfg.trigmod),
		.trig_i    (trig_i),
		.trig_o    (trig_o)
	);

	cw_power_fsm i_power (
		.clk                (clk),
		.reset              (reset),
		.extra_i            (cfg.ioroute.extra),
		.pwm_off_i          (pwm_off),
		.done_i             (done),
		.run_o              (run),
		.power_off_q_o      (power_off_q),
		.target_power_off_o (target_power_off_o)
	);

	cw_ramp_timer i_ramp (
		.clk       (clk),
		.reset     (reset),
		.run_i     (run),
		.pwm_off_o (pwm_off),
		.done_o    (done)
	);

	cw_target_io i_io (
		.ioroute_i  (cfg.ioroute),
		.highz_i    (power_off_q),
		.uart_tx_i  (uart_tx_i),
		.usi_out_i  (usi_out_i),
		.pins_i     (pins_i),
		.pins_o     (pins_o),
		.uart_rx_o  (uart_rx_o),
		.usi_in_o   (usi_in_o),
		.avr_prog_o (avr_prog_o),
		.aux_oe_o   (aux_oe_o),
		.aux_val_o  (aux_val_o)
	);

endmodule

`default_nettype wire

//--- design/cw_target_io.sv
`timescale 1ns/1ps
`default_nettype none

module cw_target_io (
	input  cw_pkg::io_route_t  ioroute_i,
	input  logic               highz_i,
	input  logic               uart_tx_i,
	input  logic               usi_out_i,
	input  logic [3:0]         pins_i,
	output cw_pkg::pin_drive_t pins_o,
	output logic               uart_rx_o,
	output logic               usi_in_o,
	output logic               avr_prog_o,
	output logic [2:0]         aux_oe_o,
	output logic [2:0]         aux_val_o
);

	// drive priority per pin, lowest config bit wins
	always_comb begin
		cw_pkg::gpio_cfg_t g;
		pins_o = '0;
		for (int i = 0; i < 4; i++) begin
			g = ioroute_i.gpio[i];
			if (highz_i) begin
				pins_o.oe[i] = 1'b0;  // target unpowered, release everything
			end else if (g.uart_tx) begin
				pins_o.oe[i]  = 1'b1;
				pins_o.val[i] = uart_tx_i;
			end else if (g.usi_tx) begin
				pins_o.oe[i]  = 1'b1;
				pins_o.val[i] = usi_out_i;
			end else if (i == 2 && g.usio_oc) begin
				pins_o.oe[i] = ~usi_out_i;  // pull low only, val stays 0
			end else if (i == 2 && g.txo_oc) begin
				pins_o.oe[i] = ~uart_tx_i;
			end else if (g.drive_en) begin
				pins_o.oe[i]  = 1'b1;
				pins_o.val[i] = g.drive_val;
			end
		end
	end

	// receive selects, walked backwards so pin 1 has priority
	always_comb begin
		uart_rx_o = 1'b1;  // idle high when unrouted
		usi_in_o  = 1'b1;
		for (int i = 3; i >= 0; i--) begin
			if (ioroute_i.gpio[i].uart_rx) uart_rx_o = pins_i[i];
		end
		for (int i = 2; i >= 0; i--) begin
			if (ioroute_i.gpio[i].usi_rx) usi_in_o = pins_i[i];  // pins 1..3 only
		end
	end

	assign avr_prog_o = ioroute_i.extra.avr_prog;
	assign aux_oe_o   = {ioroute_i.aux.pdic_en, ioroute_i.aux.pdid_en, ioroute_i.aux.nrst_en};
	assign aux_val_o  = {ioroute_i.aux.pdic, ioroute_i.aux.pdid, ioroute_i.aux.nrst};

endmodule

`default_nettype wire

//--- design/cw_trigger_route.sv
`timescale 1ns/1ps
`default_nettype none

module cw_trigger_route (
	input  cw_pkg::trigsrc_t  trigsrc_i,
	input  cw_pkg::trigmod_t  trigmod_i,
	input  cw_pkg::trig_in_t  trig_i,
	output cw_pkg::trig_out_t trig_o
);

	logic [5:0] lines;     // external lines in enable bit order
	logic [4:0] mods;      // trigger modules, codes 1..5
	logic       comb_or;
	logic       comb_and;
	logic       ext;
	logic       pri;
	logic       sec;

	// code 0 picks src[0], codes above 5 give low
	function automatic logic pick(input logic [2:0] code, input logic [5:0] src);
		logic res;
		res = 1'b0;
		if (code <= 3'd5) begin
			res = src[code];
		end
		return res;
	endfunction

	assign lines = {trig_i.io4, trig_i.io3, trig_i.io2, trig_i.io1, trig_i.fpb, trig_i.fpa};
	assign mods  = {trig_i.edge_trig, trig_i.mmc, trig_i.decodedio,
	                trig_i.anapattern, trig_i.advio};

	assign comb_or  = |(lines & trigsrc_i.enables);   // disabled lines ignored
	assign comb_and = &(lines | ~trigsrc_i.enables);  // disabled lines count high

	always_comb begin
		case (trigsrc_i.mode)
			2'd0:    ext = comb_or;
			2'd1:    ext = comb_and;
			2'd2:    ext = ~comb_and;
			default: ext = 1'b0;
		endcase
	end

	assign pri = pick(trigmod_i.pri_sel, {mods, ext});
	assign sec = pick(trigmod_i.sec_sel, {mods, 1'b0});  // 0 means off here

	assign trig_o.trigger = {sec, pri};
	assign trig_o.ext     = ext;
	assign trig_o.fp_val  = pri | sec;  // both panel outputs carry either trigger
	assign trig_o.fpa_oe  = trigmod_i.fpa_out;
	assign trig_o.fpb_oe  = trigmod_i.fpb_out;

endmodule

`default_nettype wire

//--- sim.f
design/cw_pkg.sv
design/cw_reg_file.sv
design/cw_trigger_route.sv
design/cw_power_fsm.sv
design/cw_ramp_timer.sv
design/cw_target_io.sv
design/cw_route_top.sv
bench/cw_route_chk.sv
bench/cw_route_tb.sv
